// ==== hdl/pcie_ep_cfg.svh ====
`ifndef PCIE_EP_CFG_SVH
`define PCIE_EP_CFG_SVH

// ----------------------------------------
// Local qword buffer and write TLP limits
// ----------------------------------------
`define BUF_AW          9               // 512 qwords of packet buffer
`define MAX_TLP_QWORDS  16              // 128 byte max payload
`define PAGE_QWORDS     64              // Host page size in qwords

// ----------------------------------------
// BAR0 register map, byte offsets
// ----------------------------------------
`define REG_PAGE0       8'h00           // Page 0 base address
`define REG_PAGE1       8'h08           // Page 1 base address
`define REG_IRQ_EN      8'h10           // Bit 0 enables the legacy interrupt

// ----------------------------------------
// TLP fmt/type codes
// ----------------------------------------
`define FMT_TYPE_MWR32  8'h40           // 3DW memory write from host
`define FMT_TYPE_MWR64  8'h60           // 4DW memory write to host

`endif

// ==== hdl/pcie_ep_pkg.sv ====
`include "pcie_ep_cfg.svh"

package pcie_ep_pkg;

    // ----------------------------------------
    // Vectors with a meaning
    // ----------------------------------------
    typedef logic [63:0]         qword_t;          // One local-link beat
    typedef logic [63:0]         host_addr_t;      // Host byte address
    typedef logic [`BUF_AW-1:0]  buf_ptr_t;        // Qword index into the buffer
    typedef logic [4:0]          qword_cnt_t;      // Payload length, 1 to 16
    typedef logic [15:0]         completer_id_t;   // Bus, device, function
    typedef logic [7:0]          reg_ofs_t;        // BAR0 register offset

    // ----------------------------------------
    // Grouped signals
    // ----------------------------------------
    typedef struct packed {
        host_addr_t  page0_addr;
        host_addr_t  page1_addr;
        logic [1:0]  ready;                        // Page owned by the engine
        logic        irq_en;
    } page_regs_t;

    typedef struct packed {
        host_addr_t  addr;                         // Host target of the TLP
        buf_ptr_t    start;                        // First buffer qword
        qword_cnt_t  count;                        // Payload qwords
    } tlp_cmd_t;

    typedef struct packed {
        qword_t      data;
        logic        sof;                          // Active high here
        logic        eof;
        logic        valid;
        logic        bar0_hit;
    } rx_beat_t;

    // ----------------------------------------
    // State machines
    // ----------------------------------------
    typedef enum logic [1:0] {
        ENG_IDLE,                                  // Look for data and a ready page
        ENG_REQ,                                   // Req high until ack rises
        ENG_ACK_LOW                                // Wait for ack to drop
    } engine_state_t;

    typedef enum logic [2:0] {
        FR_IDLE,
        FR_HDR0,                                   // DW0 and DW1
        FR_HDR1,                                   // 64-bit address
        FR_PAYLOAD,
        FR_DONE                                    // Eof out, then ack
    } framer_state_t;

endpackage

// ==== hdl/page_reg_decode.sv ====
`include "pcie_ep_cfg.svh"

module page_reg_decode (
    input  logic                     trn_clk,
    input  logic                     reset,
    input  pcie_ep_pkg::rx_beat_t    rx_beat,
    input  logic [1:0]               page_free,
    output pcie_ep_pkg::page_regs_t  page_regs
);

    logic [1:0]               beat_cnt;    // Beat index inside the TLP
    logic                     hdr_ok;      // MWr32, 2 DW, BAR0
    pcie_ep_pkg::reg_ofs_t    reg_sel;
    logic [31:0]              data_lo;     // Data DW0 from beat 1
    pcie_ep_pkg::host_addr_t  wr_val;
    logic                     wr_en;
    logic                     wr_page0;
    logic                     wr_page1;
    pcie_ep_pkg::host_addr_t  page0_q;
    pcie_ep_pkg::host_addr_t  page1_q;
    logic [1:0]               ready_q;
    logic                     irq_en_q;

    // ----------------------------------------
    // Write strobe on the third beat
    // ----------------------------------------
    assign wr_en    = rx_beat.valid && rx_beat.eof && !rx_beat.sof &&
                      beat_cnt == 2'd2 && hdr_ok;
    assign wr_val   = {rx_beat.data[63:32], data_lo};    // {DW1, DW0}
    assign wr_page0 = wr_en && reg_sel == `REG_PAGE0;
    assign wr_page1 = wr_en && reg_sel == `REG_PAGE1;

    always_ff @(posedge trn_clk) begin
        if (reset) begin
            beat_cnt <= 2'd0;
            hdr_ok   <= 1'b0;
        end else if (rx_beat.valid) begin
            if (rx_beat.sof) begin
                beat_cnt <= 2'd1;
                hdr_ok   <= rx_beat.bar0_hit &&
                            rx_beat.data[63:56] == `FMT_TYPE_MWR32 &&
                            rx_beat.data[41:32] == 10'd2;     // Length in DW
            end else if (beat_cnt != 2'd3) begin
                beat_cnt <= beat_cnt + 2'd1;                  // Saturates on long TLPs
            end
        end
    end

    // Address DW up, data DW0 down
    always_ff @(posedge trn_clk) begin
        if (rx_beat.valid && !rx_beat.sof && beat_cnt == 2'd1) begin
            reg_sel <= rx_beat.data[39:32];
            data_lo <= rx_beat.data[31:0];
        end
    end

    // ----------------------------------------
    // Register file
    // ----------------------------------------
    always_ff @(posedge trn_clk) begin
        if (wr_page0) begin
            page0_q <= wr_val;
        end
        if (wr_page1) begin
            page1_q <= wr_val;
        end
    end

    always_ff @(posedge trn_clk) begin
        if (reset) begin
            ready_q  <= 2'b00;
            irq_en_q <= 1'b0;
        end else begin
            ready_q <= (ready_q & ~page_free) | {wr_page1, wr_page0};   // Host write wins
            if (wr_en && reg_sel == `REG_IRQ_EN) begin
                irq_en_q <= data_lo[0];
            end
        end
    end

    assign page_regs = '{page0_addr: page0_q,
                         page1_addr: page1_q,
                         ready:      ready_q,
                         irq_en:     irq_en_q};

endmodule

// ==== hdl/dma_write_engine.sv ====
`include "pcie_ep_cfg.svh"

module dma_write_engine (
    input  logic                     trn_clk,
    input  logic                     reset,
    input  pcie_ep_pkg::page_regs_t  page_regs,
    output logic [1:0]               page_free,
    input  pcie_ep_pkg::buf_ptr_t    commited_wr_addr,
    output pcie_ep_pkg::buf_ptr_t    commited_rd_addr,
    output pcie_ep_pkg::tlp_cmd_t    cmd,
    output logic                     cmd_req,
    input  logic                     cmd_ack,
    output logic                     cfg_interrupt_n,
    input  logic                     cfg_interrupt_rdy_n
);

    localparam int OFS_W = $clog2(`PAGE_QWORDS) + 1;    // Holds 0 to PAGE_QWORDS

    pcie_ep_pkg::engine_state_t  state;
    logic                        cur_page;               // Page being filled
    logic [OFS_W-1:0]            page_ofs;               // Qwords already in the page
    logic [OFS_W-1:0]            page_left;
    pcie_ep_pkg::buf_ptr_t       avail;                  // Qwords waiting in the buffer
    pcie_ep_pkg::qword_cnt_t     tlp_cnt;
    pcie_ep_pkg::host_addr_t     page_base;
    logic                        start;
    logic                        page_done;
    logic                        irq_pend;

    // ----------------------------------------
    // Next TLP size and target
    // ----------------------------------------
    assign avail     = commited_wr_addr - commited_rd_addr;       // Wraps with the buffer
    assign page_left = OFS_W'(`PAGE_QWORDS) - page_ofs;
    assign page_base = cur_page ? page_regs.page1_addr : page_regs.page0_addr;
    assign start     = state == pcie_ep_pkg::ENG_IDLE &&
                       page_regs.ready[cur_page] && avail != '0;
    assign page_done = state == pcie_ep_pkg::ENG_REQ && cmd_ack &&
                       page_ofs + OFS_W'(cmd.count) == OFS_W'(`PAGE_QWORDS);

    // Minimum of buffer fill, TLP limit and page room
    always_comb begin
        int unsigned n;
        n = `MAX_TLP_QWORDS;
        if (avail < n) begin
            n = avail;
        end
        if (page_left < n) begin
            n = page_left;
        end
        tlp_cnt = pcie_ep_pkg::qword_cnt_t'(n);
    end

    // Held stable while req is high
    always_ff @(posedge trn_clk) begin
        if (start) begin
            cmd.addr  <= page_base + pcie_ep_pkg::host_addr_t'({page_ofs, 3'b000});
            cmd.start <= commited_rd_addr;
            cmd.count <= tlp_cnt;
        end
    end

    // ----------------------------------------
    // Req/ack sequencing and page tracking
    // ----------------------------------------
    always_ff @(posedge trn_clk) begin
        if (reset) begin
            state            <= pcie_ep_pkg::ENG_IDLE;
            cmd_req          <= 1'b0;
            cur_page         <= 1'b0;
            page_ofs         <= '0;
            commited_rd_addr <= '0;
            page_free        <= 2'b00;
        end else begin
            page_free <= 2'b00;                                   // Single cycle pulse
            case (state)
                pcie_ep_pkg::ENG_IDLE: begin
                    if (start) begin
                        cmd_req <= 1'b1;
                        state   <= pcie_ep_pkg::ENG_REQ;
                    end
                end
                pcie_ep_pkg::ENG_REQ: begin
                    if (cmd_ack) begin                            // Rising ack
                        cmd_req          <= 1'b0;
                        commited_rd_addr <= commited_rd_addr +
                                            pcie_ep_pkg::buf_ptr_t'(cmd.count);
                        if (page_done) begin
                            page_ofs  <= '0;
                            cur_page  <= ~cur_page;               // Ping-pong
                            page_free <= cur_page ? 2'b10 : 2'b01;
                        end else begin
                            page_ofs <= page_ofs + OFS_W'(cmd.count);
                        end
                        state <= pcie_ep_pkg::ENG_ACK_LOW;
                    end
                end
                pcie_ep_pkg::ENG_ACK_LOW: begin
                    if (!cmd_ack) begin
                        state <= pcie_ep_pkg::ENG_IDLE;
                    end
                end
                default: state <= pcie_ep_pkg::ENG_IDLE;
            endcase
        end
    end

    // ----------------------------------------
    // Legacy interrupt handshake
    // ----------------------------------------
    always_ff @(posedge trn_clk) begin
        if (reset) begin
            cfg_interrupt_n <= 1'b1;
            irq_pend        <= 1'b0;
        end else begin
            if (cfg_interrupt_n && irq_pend) begin
                cfg_interrupt_n <= 1'b0;
                irq_pend        <= 1'b0;
            end else if (!cfg_interrupt_n && !cfg_interrupt_rdy_n) begin
                cfg_interrupt_n <= 1'b1;                          // Core took it
            end
            if (page_done && page_regs.irq_en) begin
                irq_pend <= 1'b1;                                 // Kept if one is in flight
            end
        end
    end

endmodule

// ==== hdl/tlp_tx_framer.sv ====
`include "pcie_ep_cfg.svh"

module tlp_tx_framer (
    input  logic                        trn_clk,
    input  logic                        reset,
    input  pcie_ep_pkg::tlp_cmd_t       cmd,
    input  logic                        cmd_req,
    output logic                        cmd_ack,
    input  pcie_ep_pkg::completer_id_t  cfg_completer_id,
    output pcie_ep_pkg::qword_t         trn_td,
    output logic [7:0]                  trn_trem_n,
    output logic                        trn_tsof_n,
    output logic                        trn_teof_n,
    output logic                        trn_tsrc_rdy_n,
    input  logic                        trn_tdst_rdy_n,
    output pcie_ep_pkg::buf_ptr_t       rd_addr,
    input  pcie_ep_pkg::qword_t         rd_data
);

    pcie_ep_pkg::framer_state_t  state;
    pcie_ep_pkg::qword_cnt_t     fetch_left;    // RAM reads still to issue
    pcie_ep_pkg::qword_cnt_t     beats_left;    // Payload beats still to load
    pcie_ep_pkg::qword_t         pf_q;          // Prefetch slot
    logic                        pf_vld;
    logic                        fetch_vld;     // rd_data valid this cycle
    logic                        out_free;      // Output beat empty or taken
    logic                        issue;
    logic                        load_pay;
    pcie_ep_pkg::qword_t         hdr0;

    assign out_free   = trn_tsrc_rdy_n | ~trn_tdst_rdy_n;
    assign issue      = out_free && fetch_left != '0 &&
                        (state == pcie_ep_pkg::FR_HDR1 || state == pcie_ep_pkg::FR_PAYLOAD);
    assign load_pay   = state == pcie_ep_pkg::FR_PAYLOAD && out_free && (pf_vld || fetch_vld);
    assign trn_trem_n = 8'h00;                  // Always full qwords

    // DW0 then DW1, length counted in DW
    assign hdr0 = {`FMT_TYPE_MWR64, 8'h00, 6'b000000, 4'b0000, cmd.count, 1'b0,
                   cfg_completer_id, 8'h00, 8'hFF};

    // ----------------------------------------
    // Prefetch of the RAM output
    // ----------------------------------------
    always_ff @(posedge trn_clk) begin
        if (load_pay) begin
            pf_vld <= 1'b0;
        end else if (fetch_vld) begin
            pf_q   <= rd_data;                  // Stalled, park the read
            pf_vld <= 1'b1;
        end
        if (reset) begin
            pf_vld <= 1'b0;
        end
    end

    // ----------------------------------------
    // Beat sequencing
    // ----------------------------------------
    always_ff @(posedge trn_clk) begin
        if (reset) begin
            state          <= pcie_ep_pkg::FR_IDLE;
            cmd_ack        <= 1'b0;
            trn_tsrc_rdy_n <= 1'b1;
            trn_tsof_n     <= 1'b1;
            trn_teof_n     <= 1'b1;
            fetch_vld      <= 1'b0;
            fetch_left     <= '0;
            beats_left     <= '0;
            rd_addr        <= '0;
        end else begin
            fetch_vld <= issue;
            if (issue) begin
                rd_addr    <= rd_addr + 1'b1;
                fetch_left <= fetch_left - 1'b1;
            end
            if (out_free) begin
                trn_tsrc_rdy_n <= 1'b1;         // Drained unless reloaded below
            end
            case (state)
                pcie_ep_pkg::FR_IDLE: begin
                    if (cmd_req) begin
                        rd_addr    <= cmd.start;
                        fetch_left <= cmd.count;
                        beats_left <= cmd.count;
                        state      <= pcie_ep_pkg::FR_HDR0;
                    end
                end
                pcie_ep_pkg::FR_HDR0: begin
                    if (out_free) begin
                        trn_td         <= hdr0;
                        trn_tsrc_rdy_n <= 1'b0;
                        trn_tsof_n     <= 1'b0;
                        trn_teof_n     <= 1'b1;
                        state          <= pcie_ep_pkg::FR_HDR1;
                    end
                end
                pcie_ep_pkg::FR_HDR1: begin
                    if (out_free) begin
                        trn_td         <= cmd.addr;     // Address high then low
                        trn_tsrc_rdy_n <= 1'b0;
                        trn_tsof_n     <= 1'b1;
                        state          <= pcie_ep_pkg::FR_PAYLOAD;
                    end
                end
                pcie_ep_pkg::FR_PAYLOAD: begin
                    if (load_pay) begin
                        trn_td         <= pf_vld ? pf_q : rd_data;
                        trn_tsrc_rdy_n <= 1'b0;
                        trn_teof_n     <= beats_left != 5'd1;
                        beats_left     <= beats_left - 1'b1;
                        if (beats_left == 5'd1) begin
                            state <= pcie_ep_pkg::FR_DONE;
                        end
                    end
                end
                pcie_ep_pkg::FR_DONE: begin
                    if (cmd_ack) begin
                        if (!cmd_req) begin     // Four-phase close
                            cmd_ack <= 1'b0;
                            state   <= pcie_ep_pkg::FR_IDLE;
                        end
                    end else if (!trn_tsrc_rdy_n && !trn_tdst_rdy_n) begin
                        trn_teof_n <= 1'b1;     // Eof beat taken
                        cmd_ack    <= 1'b1;
                    end
                end
                default: state <= pcie_ep_pkg::FR_IDLE;
            endcase
        end
    end

endmodule

// ==== hdl/pcie_dma_top.sv ====
module pcie_dma_top (
    input  logic                   trn_clk,
    input  logic                   reset,
    // Rx local-link
    input  pcie_ep_pkg::qword_t    trn_rd,
    input  logic                   trn_rsof_n,
    input  logic                   trn_reof_n,
    input  logic                   trn_rsrc_rdy_n,
    input  logic [6:0]             trn_rbar_hit_n,
    // Tx local-link
    output pcie_ep_pkg::qword_t    trn_td,
    output logic [7:0]             trn_trem_n,
    output logic                   trn_tsof_n,
    output logic                   trn_teof_n,
    output logic                   trn_tsrc_rdy_n,
    input  logic                   trn_tdst_rdy_n,
    // Configuration and interrupt
    input  logic [7:0]             cfg_bus_number,
    input  logic [4:0]             cfg_device_number,
    input  logic [2:0]             cfg_function_number,
    output logic                   cfg_interrupt_n,
    input  logic                   cfg_interrupt_rdy_n,
    // Packet buffer
    input  pcie_ep_pkg::buf_ptr_t  commited_wr_addr,
    output pcie_ep_pkg::buf_ptr_t  commited_rd_addr,
    output pcie_ep_pkg::buf_ptr_t  rd_addr,
    input  pcie_ep_pkg::qword_t    rd_data
);

    pcie_ep_pkg::rx_beat_t       rx_beat;
    pcie_ep_pkg::page_regs_t     page_regs;
    pcie_ep_pkg::tlp_cmd_t       cmd;
    pcie_ep_pkg::completer_id_t  cfg_completer_id;
    logic [1:0]                  page_free;
    logic                        cmd_req;
    logic                        cmd_ack;

    // ----------------------------------------
    // Active high view of the rx beat
    // ----------------------------------------
    assign rx_beat = '{data:     trn_rd,
                       sof:      ~trn_rsof_n,
                       eof:      ~trn_reof_n,
                       valid:    ~trn_rsrc_rdy_n,
                       bar0_hit: ~trn_rbar_hit_n[0]};

    assign cfg_completer_id = {cfg_bus_number, cfg_device_number, cfg_function_number};

    page_reg_decode page_reg_decode_mod (
        .trn_clk   (trn_clk),
        .reset     (reset),
        .rx_beat   (rx_beat),
        .page_free (page_free),            // From engine
        .page_regs (page_regs)
    );

    dma_write_engine dma_write_engine_mod (
        .trn_clk             (trn_clk),
        .reset               (reset),
        .page_regs           (page_regs),
        .page_free           (page_free),
        .commited_wr_addr    (commited_wr_addr),
        .commited_rd_addr    (commited_rd_addr),
        .cmd                 (cmd),
        .cmd_req             (cmd_req),   // Four-phase with the framer
        .cmd_ack             (cmd_ack),
        .cfg_interrupt_n     (cfg_interrupt_n),
        .cfg_interrupt_rdy_n (cfg_interrupt_rdy_n)
    );

    tlp_tx_framer tlp_tx_framer_mod (
        .trn_clk          (trn_clk),
        .reset            (reset),
        .cmd              (cmd),
        .cmd_req          (cmd_req),
        .cmd_ack          (cmd_ack),
        .cfg_completer_id (cfg_completer_id),
        .trn_td           (trn_td),
        .trn_trem_n       (trn_trem_n),
        .trn_tsof_n       (trn_tsof_n),
        .trn_teof_n       (trn_teof_n),
        .trn_tsrc_rdy_n   (trn_tsrc_rdy_n),
        .trn_tdst_rdy_n   (trn_tdst_rdy_n),
        .rd_addr          (rd_addr),       // Buffer read port
        .rd_data          (rd_data)
    );

endmodule

// ==== tests/tb_pcie_dma.sv ====
`include "pcie_ep_cfg.svh"

module tb_pcie_dma;

    logic                   trn_clk;
    logic                   reset;
    pcie_ep_pkg::qword_t    trn_rd;
    logic                   trn_rsof_n;
    logic                   trn_reof_n;
    logic                   trn_rsrc_rdy_n;
    logic [6:0]             trn_rbar_hit_n;
    pcie_ep_pkg::qword_t    trn_td;
    logic [7:0]             trn_trem_n;
    logic                   trn_tsof_n;
    logic                   trn_teof_n;
    logic                   trn_tsrc_rdy_n;
    logic                   trn_tdst_rdy_n;
    logic                   cfg_interrupt_n;
    logic                   cfg_interrupt_rdy_n;
    pcie_ep_pkg::buf_ptr_t  commited_wr_addr;
    pcie_ep_pkg::buf_ptr_t  commited_rd_addr;
    pcie_ep_pkg::buf_ptr_t  rd_addr;
    pcie_ep_pkg::qword_t    rd_data;

    localparam logic [15:0] CPL_ID  = 16'h0311;                 // Bus 3, device 2, function 1
    localparam logic [63:0] PAGE0_A = 64'h0000_0000_1000_0000;
    localparam logic [63:0] PAGE1_A = 64'h0000_0001_2000_0000; // Upper DW in use
    localparam logic [63:0] PAGE0_B = 64'h0000_0000_3000_0000;

    int    seed = 32'hf4e4;
    string cur_test;
    int    test_errs;
    int    total_errs;
    int    tests_done;
    int    tests_bad;

    pcie_dma_top pcie_dma_top_i (
        .trn_clk             (trn_clk),
        .reset               (reset),
        .trn_rd              (trn_rd),
        .trn_rsof_n          (trn_rsof_n),
        .trn_reof_n          (trn_reof_n),
        .trn_rsrc_rdy_n      (trn_rsrc_rdy_n),
        .trn_rbar_hit_n      (trn_rbar_hit_n),
        .trn_td              (trn_td),
        .trn_trem_n          (trn_trem_n),
        .trn_tsof_n          (trn_tsof_n),
        .trn_teof_n          (trn_teof_n),
        .trn_tsrc_rdy_n      (trn_tsrc_rdy_n),
        .trn_tdst_rdy_n      (trn_tdst_rdy_n),
        .cfg_bus_number      (8'h03),
        .cfg_device_number   (5'h02),
        .cfg_function_number (3'h1),
        .cfg_interrupt_n     (cfg_interrupt_n),
        .cfg_interrupt_rdy_n (cfg_interrupt_rdy_n),
        .commited_wr_addr    (commited_wr_addr),
        .commited_rd_addr    (commited_rd_addr),
        .rd_addr             (rd_addr),
        .rd_data             (rd_data)
    );

    initial begin
        trn_clk = 1'b0;
        forever #2 trn_clk = ~trn_clk;                          // Period 4
    end

    // ----------------------------------------
    // Buffer model and expected words
    // ----------------------------------------
    function automatic logic [63:0] fill_word(input pcie_ep_pkg::buf_ptr_t idx);
        return {32'hA5A5_0000 + 32'(idx), 32'(idx)};
    endfunction

    // MWr64 DW0 then DW1 with byte enables FF
    function automatic logic [63:0] hdr_word(input int n);
        return {8'h60, 8'h00, 6'b000000, 10'(2 * n), CPL_ID, 8'h00, 8'hFF};
    endfunction

    initial begin
        pcie_ep_pkg::buf_ptr_t addr_q;
        rd_data = '0;
        addr_q  = '0;
        forever begin
            @(posedge trn_clk);
            #1;
            rd_data = fill_word(addr_q);                        // One cycle read latency
            addr_q  = rd_addr;
        end
    end

    // ----------------------------------------
    // Drivers and checkers
    // ----------------------------------------
    task automatic next_cycle();
        @(posedge trn_clk);
        #1;                                                     // Drive and sample here
    endtask

    task automatic report_error(input string msg);
        $display("error in %s: %s", cur_test, msg);
        test_errs++;
    endtask

    task automatic check_value(input string what, input logic [63:0] exp,
                               input logic [63:0] act);
        assert (act === exp) else begin
            $display("mismatch %s %s: expected %h, actual %h", cur_test, what, exp, act);
            test_errs++;
        end
    endtask

    task automatic begin_test(input string name);
        cur_test  = name;
        test_errs = 0;
    endtask

    task automatic end_test();
        $display("%s: %0d errors", cur_test, test_errs);
        total_errs += test_errs;
        tests_done++;
        if (test_errs != 0) begin
            tests_bad++;
        end
    endtask

    task automatic apply_reset();
        next_cycle();
        reset            = 1'b1;
        commited_wr_addr = '0;
        trn_tdst_rdy_n   = 1'b1;
        repeat (8) next_cycle();
        reset = 1'b0;
        next_cycle();
    endtask

    // MWr32 to BAR0 in two beats when the length is one DW
    task automatic host_reg_write(input logic [7:0] ofs, input logic [63:0] val,
                                  input bit bar_hit, input int len_dw);
        next_cycle();
        trn_rsrc_rdy_n = 1'b0;
        trn_rsof_n     = 1'b0;
        trn_reof_n     = 1'b1;
        trn_rbar_hit_n = bar_hit ? 7'h7E : 7'h7F;
        trn_rd         = {8'h40, 8'h00, 6'b000000, 10'(len_dw), 16'h0000, 8'h00, 8'hFF};
        next_cycle();
        trn_rsof_n = 1'b1;
        trn_reof_n = (len_dw == 1) ? 1'b0 : 1'b1;
        trn_rd     = {32'hF000_0000 | 32'(ofs), val[31:0]};      // Address DW, data DW0
        if (len_dw != 1) begin
            next_cycle();
            trn_reof_n = 1'b0;
            trn_rd     = {val[63:32], 32'h0000_0000};
        end
        next_cycle();
        trn_rsrc_rdy_n = 1'b1;
        trn_reof_n     = 1'b1;
        trn_rbar_hit_n = 7'h7F;
        trn_rd         = '0;
        next_cycle();                                           // Register now live
    endtask

    task automatic push_qwords(input int n);
        next_cycle();
        commited_wr_addr = commited_wr_addr + pcie_ep_pkg::buf_ptr_t'(n);
    endtask

    // Collect one TLP and compare every beat
    task automatic collect_tlp(input int n, input logic [63:0] addr, input int first,
                               input bit stall);
        int beat;
        int cycles;
        bit got_eof;
        beat    = 0;
        cycles  = 0;
        got_eof = 1'b0;
        while (!got_eof && cycles < 400) begin
            next_cycle();
            cycles++;
            trn_tdst_rdy_n = stall ? (($random(seed) & 3) == 0) : 1'b0;
            if (!trn_tsrc_rdy_n && !trn_tdst_rdy_n) begin       // Beat taken at next edge
                check_value("sof", 64'(beat == 0), 64'(!trn_tsof_n));
                check_value("eof", 64'(beat == n + 1), 64'(!trn_teof_n));
                check_value("trem", 64'h0, 64'(trn_trem_n));
                if (beat == 0) begin
                    check_value("header", hdr_word(n), trn_td);
                end else if (beat == 1) begin
                    check_value("address", addr, trn_td);
                end else begin
                    check_value($sformatf("payload %0d", beat - 2),
                                fill_word(pcie_ep_pkg::buf_ptr_t'(first + beat - 2)), trn_td);
                end
                got_eof = !trn_teof_n;
                beat++;
            end
        end
        next_cycle();
        trn_tdst_rdy_n = 1'b1;                                  // Park link between TLPs
        assert (got_eof) else report_error($sformatf("no eof within 400 cycles, %0d beats", beat));
        check_value("beat count", 64'(n + 2), 64'(beat));
    endtask

    task automatic wait_rd_ptr(input int exp);
        int cycles;
        cycles = 0;
        while (commited_rd_addr != pcie_ep_pkg::buf_ptr_t'(exp) && cycles < 20) begin
            next_cycle();
            cycles++;
        end
        check_value("commited_rd_addr", 64'(exp), 64'(commited_rd_addr));
    endtask

    task automatic expect_no_tlp(input int cycles);
        int i;
        bit seen;
        seen = 1'b0;
        for (i = 0; i < cycles && !seen; i++) begin
            next_cycle();
            seen = !trn_tsrc_rdy_n;
        end
        assert (!seen) else report_error($sformatf("TLP started after %0d idle cycles", i));
    endtask

    // ----------------------------------------
    // Directed tests
    // ----------------------------------------
    task automatic reset_and_idle();
        begin_test("reset_and_idle");
        apply_reset();
        check_value("trn_tsrc_rdy_n", 64'h1, 64'(trn_tsrc_rdy_n));
        check_value("trn_tsof_n", 64'h1, 64'(trn_tsof_n));
        check_value("trn_teof_n", 64'h1, 64'(trn_teof_n));
        check_value("cfg_interrupt_n", 64'h1, 64'(cfg_interrupt_n));
        check_value("commited_rd_addr", 64'h0, 64'(commited_rd_addr));
        push_qwords(7);
        expect_no_tlp(200);                                     // No page programmed
        end_test();
    endtask

    task automatic single_write();
        begin_test("single_write");
        apply_reset();
        host_reg_write(`REG_PAGE0, PAGE0_A, 1'b1, 2);
        push_qwords(5);
        collect_tlp(5, PAGE0_A, 0, 1'b0);
        wait_rd_ptr(5);
        end_test();
    endtask

    task automatic split_burst();
        begin_test("split_burst");
        push_qwords(40);
        collect_tlp(16, PAGE0_A + 8 * 5, 5, 1'b1);
        collect_tlp(16, PAGE0_A + 8 * 21, 21, 1'b1);
        collect_tlp(8, PAGE0_A + 8 * 37, 37, 1'b1);
        wait_rd_ptr(45);
        end_test();
    endtask

    task automatic page_switch_irq();
        int cycles;
        begin_test("page_switch_irq");
        host_reg_write(`REG_PAGE1, PAGE1_A, 1'b1, 2);
        host_reg_write(`REG_IRQ_EN, 64'h1, 1'b1, 2);
        push_qwords(24);
        collect_tlp(16, PAGE0_A + 8 * 45, 45, 1'b1);
        collect_tlp(3, PAGE0_A + 8 * 61, 61, 1'b1);            // Ends on the page edge
        cycles = 0;
        while (cfg_interrupt_n && cycles < 50) begin
            next_cycle();
            cycles++;
        end
        assert (!cfg_interrupt_n) else report_error("cfg_interrupt_n not asserted at page end");
        repeat (3) next_cycle();
        check_value("cfg_interrupt_n held", 64'h0, 64'(cfg_interrupt_n));
        cfg_interrupt_rdy_n = 1'b0;
        cycles = 0;
        while (!cfg_interrupt_n && cycles < 20) begin
            next_cycle();
            cycles++;
        end
        assert (cfg_interrupt_n) else report_error("cfg_interrupt_n not released by core");
        cfg_interrupt_rdy_n = 1'b1;
        collect_tlp(5, PAGE1_A, 64, 1'b0);
        wait_rd_ptr(69);
        end_test();
    endtask

    task automatic page_exhaust();
        int i;
        bit irq_seen;
        begin_test("page_exhaust");
        host_reg_write(`REG_IRQ_EN, 64'h0, 1'b1, 2);
        push_qwords(59);
        collect_tlp(16, PAGE1_A + 8 * 5, 69, 1'b1);
        collect_tlp(16, PAGE1_A + 8 * 21, 85, 1'b1);
        collect_tlp(16, PAGE1_A + 8 * 37, 101, 1'b1);
        collect_tlp(11, PAGE1_A + 8 * 53, 117, 1'b1);
        wait_rd_ptr(128);
        irq_seen = 1'b0;
        for (i = 0; i < 30; i++) begin
            next_cycle();
            irq_seen = irq_seen | !cfg_interrupt_n;
        end
        assert (!irq_seen) else report_error("cfg_interrupt_n asserted with irq_en clear");
        push_qwords(8);
        expect_no_tlp(100);                                     // Both pages freed
        host_reg_write(`REG_PAGE0, PAGE0_B, 1'b1, 2);
        collect_tlp(8, PAGE0_B, 128, 1'b0);
        wait_rd_ptr(136);
        end_test();
    endtask

    task automatic ignored_writes();
        begin_test("ignored_writes");
        host_reg_write(`REG_PAGE0, 64'h0000_0000_4000_0000, 1'b0, 2);   // Other BAR
        host_reg_write(`REG_PAGE0, 64'h0000_0000_4000_0000, 1'b1, 1);   // One DW
        host_reg_write(`REG_PAGE0, 64'h0000_0000_4000_0000, 1'b1, 3);   // Three DW
        push_qwords(4);
        collect_tlp(4, PAGE0_B + 8 * 8, 136, 1'b1);
        wait_rd_ptr(140);
        end_test();
    endtask

    // ----------------------------------------
    // Sequence
    // ----------------------------------------
    initial begin
        reset               = 1'b1;
        trn_rd              = '0;
        trn_rsof_n          = 1'b1;
        trn_rsrc_rdy_n      = 1'b1;
        trn_reof_n          = 1'b1;
        trn_rbar_hit_n      = 7'h7F;
        trn_tdst_rdy_n      = 1'b1;
        cfg_interrupt_rdy_n = 1'b1;
        commited_wr_addr    = '0;
        total_errs          = 0;
        tests_done          = 0;
        tests_bad           = 0;
        reset_and_idle();
        single_write();
        split_burst();
        page_switch_irq();
        page_exhaust();
        ignored_writes();
        $display("%0d tests, %0d with errors, %0d errors in total",
                 tests_done, tests_bad, total_errs);
        if (total_errs == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

// ==== src.f ====
+incdir+hdl
hdl/pcie_ep_pkg.sv
hdl/page_reg_decode.sv
hdl/dma_write_engine.sv
hdl/tlp_tx_framer.sv
hdl/pcie_dma_top.sv
tests/tb_pcie_dma.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the DMA write path testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f src.f --top-module tb_pcie_dma --Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/Vtb_pcie_dma)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$out" | grep -q "TESTBENCH PASSED"; then
    exit 0
fi
exit 1
